// File: verilog.f
+incdir+.
exu_pkg.sv
key_mux.sv
alu.sv
branch_unit.sv
load_extend.sv
exu.sv
exu_stage.sv
tb_exu_stage.sv

// File: tb_exu_stage.sv
// testbench for the execute stage: directed tests checked against reference model functions
`timescale 1ns/1ps
`include "exu_settings.svh"

module tb_exu_stage;

  localparam int xlen = `EXU_XLEN;
  typedef logic [xlen-1:0] data_t;

  logic                   i_clk;
  logic                   i_reset;
  logic                   i_valid;
  exu_pkg::exu_ctrl_t     i_ctrl;
  exu_pkg::exu_operands_t i_ops;
  logic                   o_valid;
  exu_pkg::exu_result_t   o_result;

  int          errors = 0;
  int          instrs = 0;
  logic [31:0] seed   = 32'hfda796cc;

  exu_stage uut (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_valid (i_valid),
    .i_ctrl  (i_ctrl),
    .i_ops   (i_ops),
    .o_valid (o_valid),
    .o_result(o_result)
  );

  initial i_clk = 1'b0;
  always #20 i_clk = ~i_clk;

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic exu_pkg::exu_operands_t random_ops();
    exu_pkg::exu_operands_t o;
    o.rs1   = {lcg_next(), lcg_next()};
    o.rs2   = {lcg_next(), lcg_next()};
    o.imm   = {lcg_next(), lcg_next()};
    o.pc    = {lcg_next(), lcg_next()};
    o.rdata = {lcg_next(), lcg_next()};
    return o;
  endfunction

  function automatic exu_pkg::exu_ctrl_t make_ctrl(exu_pkg::alu_op_e op, exu_pkg::b_src_e bs,
                                                   logic word, logic apc);
    exu_pkg::exu_ctrl_t c;
    c           = '0;
    c.alu_op    = op;
    c.b_src     = bs;
    c.word_cut  = word;
    c.a_from_pc = apc;
    return c;
  endfunction

  function automatic data_t operand_b(exu_pkg::exu_ctrl_t c, exu_pkg::exu_operands_t o);
    case (c.b_src)
      exu_pkg::b_rs2:  return o.rs2;
      exu_pkg::b_imm:  return o.imm;
      exu_pkg::b_four: return 64'd4;
      default:         return 64'd0;
    endcase
  endfunction

  function automatic data_t alu_model(exu_pkg::exu_ctrl_t c, exu_pkg::exu_operands_t o);
    data_t              a, b, r;
    logic signed [63:0] sa, sb;
    logic signed [31:0] wa, wb;
    logic        [31:0] w;
    a  = c.a_from_pc ? o.pc : o.rs1;
    b  = operand_b(c, o);
    sa = a;
    sb = b;
    wa = a[31:0];
    wb = b[31:0];
    w  = '0;
    r  = '0;
    if (c.word_cut) begin
      case (c.alu_op)
        exu_pkg::alu_add:  w = wa + wb;
        exu_pkg::alu_sub:  w = wa - wb;
        exu_pkg::alu_sll:  w = a[31:0] << b[4:0];
        exu_pkg::alu_srl:  w = a[31:0] >> b[4:0];
        exu_pkg::alu_sra:  w = wa >>> b[4:0];
        exu_pkg::alu_mul:  w = a[31:0] * b[31:0];
        exu_pkg::alu_divu: w = (b[31:0] == 0) ? 32'hffff_ffff : a[31:0] / b[31:0];
        exu_pkg::alu_remu: w = (b[31:0] == 0) ? a[31:0] : a[31:0] % b[31:0];
        exu_pkg::alu_div:
          if (wb == 0) w = 32'hffff_ffff;
          else if (a[31:0] == 32'h8000_0000 && b[31:0] == 32'hffff_ffff) w = a[31:0];
          else w = wa / wb;
        exu_pkg::alu_rem:
          if (wb == 0) w = a[31:0];
          else if (a[31:0] == 32'h8000_0000 && b[31:0] == 32'hffff_ffff) w = '0;
          else w = wa % wb;
        default: w = '0;
      endcase
      r = {{32{w[31]}}, w};
    end else begin
      case (c.alu_op)
        exu_pkg::alu_copy: r = o.imm;
        exu_pkg::alu_add:  r = a + b;
        exu_pkg::alu_sub:  r = a - b;
        exu_pkg::alu_slt:  r = (sa < sb) ? 64'd1 : 64'd0;
        exu_pkg::alu_sltu: r = (a < b) ? 64'd1 : 64'd0;
        exu_pkg::alu_xor:  r = a ^ b;
        exu_pkg::alu_and:  r = a & b;
        exu_pkg::alu_or:   r = a | b;
        exu_pkg::alu_sll:  r = a << b[5:0];
        exu_pkg::alu_srl:  r = a >> b[5:0];
        exu_pkg::alu_sra:  r = sa >>> b[5:0];
        exu_pkg::alu_mul:  r = a * b;
        exu_pkg::alu_divu: r = (b == 0) ? '1 : a / b;
        exu_pkg::alu_remu: r = (b == 0) ? a : a % b;
        exu_pkg::alu_div:
          if (b == 0) r = '1;
          else if (a == {1'b1, 63'd0} && b == '1) r = a;
          else r = sa / sb;
        exu_pkg::alu_rem:
          if (b == 0) r = a;
          else if (a == {1'b1, 63'd0} && b == '1) r = '0;
          else r = sa % sb;
        default: r = '0;
      endcase
    end
    return r;
  endfunction

  // compare flavour is unsigned only for sltu
  function automatic data_t pc_model(exu_pkg::exu_ctrl_t c, exu_pkg::exu_operands_t o);
    data_t a, b, seq, tgt;
    logic  less, eq;
    a    = c.a_from_pc ? o.pc : o.rs1;
    b    = operand_b(c, o);
    less = (c.alu_op == exu_pkg::alu_sltu) ? (a < b) : ($signed(a) < $signed(b));
    eq   = (a == b);
    seq  = o.pc + 64'd4;
    tgt  = o.pc + o.imm;
    case (c.branch)
      exu_pkg::br_jal:  return tgt;
      exu_pkg::br_jalr: return (o.rs1 + o.imm) & ~64'd1;
      exu_pkg::br_beq:  return eq ? tgt : seq;
      exu_pkg::br_bne:  return eq ? seq : tgt;
      exu_pkg::br_blt:  return less ? tgt : seq;
      exu_pkg::br_bge:  return less ? seq : tgt;
      default:          return seq;
    endcase
  endfunction

  function automatic data_t load_model(exu_pkg::mem_op_e m, data_t d);
    case (m)
      exu_pkg::mem_lb:  return {{56{d[7]}}, d[7:0]};
      exu_pkg::mem_lbu: return {56'd0, d[7:0]};
      exu_pkg::mem_lh:  return {{48{d[15]}}, d[15:0]};
      exu_pkg::mem_lhu: return {48'd0, d[15:0]};
      exu_pkg::mem_lw:  return {{32{d[31]}}, d[31:0]};
      exu_pkg::mem_lwu: return {32'd0, d[31:0]};
      default:          return d;
    endcase
  endfunction

  task automatic check_result(exu_pkg::exu_ctrl_t c, exu_pkg::exu_operands_t o);
    data_t exp_alu, exp_pc, exp_bus;
    logic  exp_halt, exp_ill;
    exp_alu  = alu_model(c, o);
    exp_pc   = pc_model(c, o);
    exp_bus  = c.mem_to_reg ? load_model(c.mem_op, o.rdata) : exp_alu;
    exp_halt = (c.alu_op == exu_pkg::alu_halt);
    exp_ill  = (c.alu_op == exu_pkg::alu_illegal);
    instrs++;
    if (o_result.alu_result !== exp_alu) begin
      errors++;
      $display("CHECK FAILED alu_result got %h expected %h", o_result.alu_result, exp_alu);
    end
    if (o_result.next_pc !== exp_pc) begin
      errors++;
      $display("CHECK FAILED next_pc got %h expected %h", o_result.next_pc, exp_pc);
    end
    if (o_result.bus_w !== exp_bus) begin
      errors++;
      $display("CHECK FAILED bus_w got %h expected %h", o_result.bus_w, exp_bus);
    end
    if (o_result.halt !== exp_halt || o_result.illegal !== exp_ill) begin
      errors++;
      $display("CHECK FAILED halt/illegal got %h/%h expected %h/%h", o_result.halt,
               o_result.illegal, exp_halt, exp_ill);
    end
  endtask

  task automatic exec(exu_pkg::exu_ctrl_t c, exu_pkg::exu_operands_t o);
    int wait_cycles;
    @(posedge i_clk);
    #2;
    i_valid = 1'b1;
    i_ctrl  = c;
    i_ops   = o;
    @(posedge i_clk);
    #2;
    i_valid     = 1'b0;
    wait_cycles = 0;
    @(negedge i_clk);
    while (!o_valid && wait_cycles < 10) begin
      @(negedge i_clk);
      wait_cycles++;
    end
    if (!o_valid) begin
      errors++;
      $display("timeout: o_valid did not rise after an instruction");
    end else begin
      check_result(c, o);
    end
  endtask

  task automatic alu_ops_test();
    exu_pkg::alu_op_e       op_list[16];
    exu_pkg::exu_operands_t o;
    data_t                  edge_a[4];
    data_t                  edge_b[4];
    op_list = '{exu_pkg::alu_copy, exu_pkg::alu_add, exu_pkg::alu_slt, exu_pkg::alu_sltu,
                exu_pkg::alu_sub, exu_pkg::alu_xor, exu_pkg::alu_and, exu_pkg::alu_or,
                exu_pkg::alu_sll, exu_pkg::alu_srl, exu_pkg::alu_sra, exu_pkg::alu_mul,
                exu_pkg::alu_div, exu_pkg::alu_divu, exu_pkg::alu_rem, exu_pkg::alu_remu};
    edge_a  = '{64'h1234, '1, 64'h7fff_ffff_ffff_ffff, 64'h8000_0000_0000_0000};
    edge_b  = '{64'h1234, 64'd1, 64'h8000_0000_0000_0000, 64'h7fff_ffff_ffff_ffff};
    for (int i = 0; i < 16; i++) begin
      for (int k = 0; k < 4; k++) begin
        o = random_ops();
        exec(make_ctrl(op_list[i], exu_pkg::b_src_e'(k % 3), 1'b0, k == 3), o);
      end
    end
    // equal, negative and extreme compares
    for (int k = 0; k < 4; k++) begin
      o     = random_ops();
      o.rs1 = edge_a[k];
      o.rs2 = edge_b[k];
      exec(make_ctrl(exu_pkg::alu_slt, exu_pkg::b_rs2, 1'b0, 1'b0), o);
      exec(make_ctrl(exu_pkg::alu_sltu, exu_pkg::b_rs2, 1'b0, 1'b0), o);
    end
  endtask

  task automatic word_ops_test();
    exu_pkg::alu_op_e       op_list[10];
    exu_pkg::exu_operands_t o;
    op_list = '{exu_pkg::alu_add, exu_pkg::alu_sub, exu_pkg::alu_sll, exu_pkg::alu_srl,
                exu_pkg::alu_sra, exu_pkg::alu_mul, exu_pkg::alu_div, exu_pkg::alu_divu,
                exu_pkg::alu_rem, exu_pkg::alu_remu};
    for (int i = 0; i < 10; i++) begin
      for (int k = 0; k < 3; k++) begin
        o = random_ops();
        exec(make_ctrl(op_list[i], (k == 2) ? exu_pkg::b_imm : exu_pkg::b_rs2, 1'b1, 1'b0), o);
      end
      // zero low word divisor, then min over minus one
      o            = random_ops();
      o.rs2[31:0]  = '0;
      exec(make_ctrl(op_list[i], exu_pkg::b_rs2, 1'b1, 1'b0), o);
      o.rs1[31:0]  = 32'h8000_0000;
      o.rs2[31:0]  = 32'hffff_ffff;
      exec(make_ctrl(op_list[i], exu_pkg::b_rs2, 1'b1, 1'b0), o);
      o.rs1        = 64'h8000_0000_0000_0000;
      o.rs2        = '1;
      exec(make_ctrl(op_list[i], exu_pkg::b_rs2, 1'b0, 1'b0), o);
      o.rs2        = '0;
      exec(make_ctrl(op_list[i], exu_pkg::b_rs2, 1'b0, 1'b0), o);
    end
  endtask

  task automatic branch_test();
    exu_pkg::exu_ctrl_t     c;
    exu_pkg::exu_operands_t o;
    data_t                  pa[3];
    data_t                  pb[3];
    // -3 vs 7 flips between signed and unsigned order
    pa = '{64'd5, -64'sd3, 64'd7};
    pb = '{64'd5, 64'd7, -64'sd3};
    for (int br = 0; br < 8; br++) begin
      for (int u = 0; u < 2; u++) begin
        for (int p = 0; p < 3; p++) begin
          o        = random_ops();
          o.rs1    = pa[p];
          o.rs2    = pb[p];
          c        = make_ctrl(u ? exu_pkg::alu_sltu : exu_pkg::alu_slt, exu_pkg::b_rs2,
                               1'b0, 1'b0);
          c.branch = exu_pkg::branch_e'(br);
          exec(c, o);
        end
      end
    end
  endtask

  task automatic load_test();
    exu_pkg::exu_ctrl_t     c;
    exu_pkg::exu_operands_t o;
    data_t                  sign_bits;
    sign_bits = 64'h8000_0000_8000_8080;
    for (int m = 0; m < 8; m++) begin
      for (int s = 0; s < 2; s++) begin
        o            = random_ops();
        o.rdata      = s ? (o.rdata | sign_bits) : (o.rdata & ~sign_bits);
        c            = make_ctrl(exu_pkg::alu_add, exu_pkg::b_rs2, 1'b0, 1'b0);
        c.mem_op     = exu_pkg::mem_op_e'(m);
        c.mem_to_reg = 1'b1;
        exec(c, o);
      end
    end
  endtask

  task automatic flag_test();
    for (int k = 0; k < 2; k++) begin
      exec(make_ctrl(exu_pkg::alu_halt, exu_pkg::b_rs2, 1'b0, 1'b0), random_ops());
      exec(make_ctrl(exu_pkg::alu_illegal, exu_pkg::b_imm, 1'b0, 1'b0), random_ops());
    end
  endtask

  // back-to-back beats, then idle cycles
  task automatic pipeline_test();
    exu_pkg::alu_op_e       op_list[4];
    exu_pkg::exu_ctrl_t     c_arr[4];
    exu_pkg::exu_operands_t o_arr[4];
    op_list = '{exu_pkg::alu_add, exu_pkg::alu_xor, exu_pkg::alu_mul, exu_pkg::alu_sltu};
    for (int k = 0; k < 4; k++) begin
      c_arr[k] = make_ctrl(op_list[k], exu_pkg::b_rs2, 1'b0, 1'b0);
      o_arr[k] = random_ops();
    end
    c_arr[1].branch = exu_pkg::br_jal;
    @(posedge i_clk);
    #2;
    i_valid = 1'b1;
    i_ctrl  = c_arr[0];
    i_ops   = o_arr[0];
    for (int k = 1; k <= 4; k++) begin
      @(posedge i_clk);
      #2;
      if (k < 4) begin
        i_ctrl = c_arr[k];
        i_ops  = o_arr[k];
      end else begin
        i_valid = 1'b0;
      end
      @(negedge i_clk);
      if (o_valid !== 1'b1) begin
        errors++;
        $display("CHECK FAILED o_valid got %h expected %h on beat %0d", o_valid, 1'b1, k - 1);
      end
      check_result(c_arr[k-1], o_arr[k-1]);
    end
    for (int k = 0; k < 3; k++) begin
      @(negedge i_clk);
      if (o_valid !== 1'b0) begin
        errors++;
        $display("CHECK FAILED o_valid got %h expected %h while idle", o_valid, 1'b0);
      end
    end
  endtask

  initial begin
    i_reset = 1'b1;
    // valid held high through reset, o_valid must still come out low
    i_valid = 1'b1;
    i_ctrl  = '0;
    i_ops   = '0;
    repeat (10) @(posedge i_clk);
    #2;
    i_reset = 1'b0;
    i_valid = 1'b0;
    @(negedge i_clk);
    if (o_valid !== 1'b0) begin
      errors++;
      $display("CHECK FAILED o_valid got %h expected %h after reset", o_valid, 1'b0);
    end
    alu_ops_test();
    word_ops_test();
    branch_test();
    load_test();
    flag_test();
    pipeline_test();
    $display("instructions checked %0d, errors %0d", instrs, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: exu_stage.sv
// execute stage: registers one instruction per valid strobe and drives the execute results
`timescale 1ns/1ps

module exu_stage (
  input  logic                   i_clk,
  input  logic                   i_reset,
  input  logic                   i_valid,
  input  exu_pkg::exu_ctrl_t     i_ctrl,
  input  exu_pkg::exu_operands_t i_ops,
  output logic                   o_valid,
  output exu_pkg::exu_result_t   o_result
);

  logic                   valid_q;
  exu_pkg::exu_ctrl_t     ctrl_q;
  exu_pkg::exu_operands_t ops_q;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      valid_q <= 1'b0;
      ctrl_q  <= '0;
    end else begin
      valid_q <= i_valid;
      if (i_valid) begin
        ctrl_q <= i_ctrl;
      end
    end
  end

  // operand payload
  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      ops_q <= i_ops;
    end
  end

  exu u_exu (
    .i_ctrl  (ctrl_q),
    .i_ops   (ops_q),
    .o_result(o_result)
  );

  assign o_valid = valid_q;

endmodule

// File: exu.sv
// execute unit: ALU, branch unit, load extension, write-back select and halt decode
`timescale 1ns/1ps
`include "exu_settings.svh"

module exu (
  input  exu_pkg::exu_ctrl_t     i_ctrl,
  input  exu_pkg::exu_operands_t i_ops,
  output exu_pkg::exu_result_t   o_result
);

  logic [`EXU_XLEN-1:0] alu_result;
  logic [`EXU_XLEN-1:0] next_pc;
  logic [`EXU_XLEN-1:0] load_value;
  exu_pkg::alu_flags_t  flags;

  alu u_alu (
    .i_ctrl  (i_ctrl),
    .i_ops   (i_ops),
    .o_result(alu_result),
    .o_flags (flags)
  );

  branch_unit u_branch (
    .i_branch (i_ctrl.branch),
    .i_flags  (flags),
    .i_rs1    (i_ops.rs1),
    .i_imm    (i_ops.imm),
    .i_pc     (i_ops.pc),
    .o_next_pc(next_pc)
  );

  load_extend u_load (
    .i_mem_op(i_ctrl.mem_op),
    .i_rdata (i_ops.rdata),
    .o_value (load_value)
  );

  always_comb begin
    o_result.alu_result = alu_result;
    o_result.next_pc    = next_pc;
    // write-back from memory or alu
    o_result.bus_w      = i_ctrl.mem_to_reg ? load_value : alu_result;
    // ebreak and bad opcode
    o_result.halt       = (i_ctrl.alu_op == exu_pkg::alu_halt);
    o_result.illegal    = (i_ctrl.alu_op == exu_pkg::alu_illegal);
  end

endmodule

// File: load_extend.sv
// load extender: picks the loaded width and sign- or zero-extends it
`timescale 1ns/1ps
`include "exu_settings.svh"

module load_extend (
  input  exu_pkg::mem_op_e     i_mem_op,
  input  logic [`EXU_XLEN-1:0] i_rdata,
  output logic [`EXU_XLEN-1:0] o_value
);

  localparam int xlen   = `EXU_XLEN;
  localparam int wlen   = `EXU_WLEN;
  localparam int byte_w = 8;
  localparam int half_w = 16;

  typedef logic [xlen-1:0] data_t;

  data_t lb_val, lbu_val, lh_val, lhu_val, lw_val, lwu_val;

  assign lb_val  = {{(xlen-byte_w){i_rdata[byte_w-1]}}, i_rdata[byte_w-1:0]};
  assign lbu_val = {{(xlen-byte_w){1'b0}}, i_rdata[byte_w-1:0]};
  assign lh_val  = {{(xlen-half_w){i_rdata[half_w-1]}}, i_rdata[half_w-1:0]};
  assign lhu_val = {{(xlen-half_w){1'b0}}, i_rdata[half_w-1:0]};
  assign lw_val  = {{(xlen-wlen){i_rdata[wlen-1]}}, i_rdata[wlen-1:0]};
  assign lwu_val = {{(xlen-wlen){1'b0}}, i_rdata[wlen-1:0]};

  // unlisted ops pass the raw doubleword
  key_mux #(.key_w(3), .nr_key(7), .payload_t(data_t)) u_ext_mux (
    .i_key    (i_mem_op),
    .i_keys   ({exu_pkg::mem_lb, exu_pkg::mem_lbu, exu_pkg::mem_lh,
                exu_pkg::mem_lhu, exu_pkg::mem_lw, exu_pkg::mem_lwu,
                exu_pkg::mem_ld}),
    .i_values ({lb_val, lbu_val, lh_val,
                lhu_val, lw_val, lwu_val,
                i_rdata}),
    .i_default(i_rdata),
    .o_value  (o_value)
  );

endmodule

// File: branch_unit.sv
// branch unit: evaluates branch conditions and forms the next PC
`timescale 1ns/1ps
`include "exu_settings.svh"

module branch_unit (
  input  exu_pkg::branch_e     i_branch,
  input  exu_pkg::alu_flags_t  i_flags,
  input  logic [`EXU_XLEN-1:0] i_rs1,
  input  logic [`EXU_XLEN-1:0] i_imm,
  input  logic [`EXU_XLEN-1:0] i_pc,
  output logic [`EXU_XLEN-1:0] o_next_pc
);

  logic                 add_imm;
  logic                 base_rs1;
  logic [`EXU_XLEN-1:0] target;

  // taken when the immediate is added to the base
  key_mux #(.key_w(3), .nr_key(7), .payload_t(logic)) u_take_mux (
    .i_key    (i_branch),
    .i_keys   ({exu_pkg::br_none, exu_pkg::br_jal, exu_pkg::br_jalr,
                exu_pkg::br_beq, exu_pkg::br_bne, exu_pkg::br_blt,
                exu_pkg::br_bge}),
    .i_values ({1'b0, 1'b1, 1'b1,
                i_flags.zero, ~i_flags.zero, i_flags.less,
                ~i_flags.less}),
    .i_default(1'b0),
    .o_value  (add_imm)
  );

  // only jalr bases on rs1
  key_mux #(.key_w(3), .nr_key(1), .payload_t(logic)) u_base_mux (
    .i_key    (i_branch),
    .i_keys   (exu_pkg::br_jalr),
    .i_values (1'b1),
    .i_default(1'b0),
    .o_value  (base_rs1)
  );

  assign target = (base_rs1 ? i_rs1 : i_pc) + (add_imm ? i_imm : `EXU_XLEN'd4);

  // jalr clears bit 0 of the target
  assign o_next_pc = base_rs1 ? {target[`EXU_XLEN-1:1], 1'b0} : target;

endmodule

// File: alu.sv
// ALU: operand selection, word cut and the RV64IM integer operations
`timescale 1ns/1ps
`include "exu_settings.svh"

module alu (
  input  exu_pkg::exu_ctrl_t     i_ctrl,
  input  exu_pkg::exu_operands_t i_ops,
  output logic [`EXU_XLEN-1:0]   o_result,
  output exu_pkg::alu_flags_t    o_flags
);

  localparam int xlen = `EXU_XLEN;
  localparam int wlen = `EXU_WLEN;

  typedef logic [xlen-1:0] data_t;

  data_t      src1, src2, imm, src_a, src_b;
  data_t      sum, diff, sll_res, srl_res, sra_res, mul_res;
  data_t      a_sx, b_sx;
  data_t      quot_s, rem_s, quot_u, rem_u;
  data_t      raw_result;
  logic       less_s, less_u, div_zero, div_ovf;
  logic [5:0] shamt;

  // word ops see zero-extended low words
  assign src1 = i_ctrl.word_cut ? {{(xlen-wlen){1'b0}}, i_ops.rs1[wlen-1:0]} : i_ops.rs1;
  assign src2 = i_ctrl.word_cut ? {{(xlen-wlen){1'b0}}, i_ops.rs2[wlen-1:0]} : i_ops.rs2;
  assign imm  = i_ctrl.word_cut ? {{(xlen-wlen){1'b0}}, i_ops.imm[wlen-1:0]} : i_ops.imm;

  assign src_a = i_ctrl.a_from_pc ? i_ops.pc : src1;

  key_mux #(.key_w(2), .nr_key(3), .payload_t(data_t)) u_b_mux (
    .i_key    (i_ctrl.b_src),
    .i_keys   ({exu_pkg::b_rs2, exu_pkg::b_imm, exu_pkg::b_four}),
    .i_values ({src2, imm, data_t'(4)}),
    .i_default(data_t'(0)),
    .o_value  (src_b)
  );

  assign sum    = src_a + src_b;
  assign diff   = src_a - src_b;
  assign less_s = $signed(src_a) < $signed(src_b);
  assign less_u = src_a < src_b;

  // flags for the branch unit
  assign o_flags.zero = (diff == '0);
  assign o_flags.less = (i_ctrl.alu_op == exu_pkg::alu_sltu) ? less_u : less_s;

  // shift amount is 5 bits for word ops
  assign shamt   = i_ctrl.word_cut ? {1'b0, src_b[4:0]} : src_b[5:0];
  assign sll_res = src_a << shamt;
  assign srl_res = src_a >> shamt;

  // sign-extended low words for sra and signed divide
  assign a_sx = i_ctrl.word_cut ? {{(xlen-wlen){src_a[wlen-1]}}, src_a[wlen-1:0]} : src_a;
  assign b_sx = i_ctrl.word_cut ? {{(xlen-wlen){src_b[wlen-1]}}, src_b[wlen-1:0]} : src_b;

  assign sra_res = $signed(a_sx) >>> shamt;
  assign mul_res = src_a * src_b;

  assign div_zero = (src_b == '0);
  assign div_ovf  = (a_sx == {1'b1, {(xlen-1){1'b0}}}) && (b_sx == '1);

  // RISC-V rules: x/0 gives all ones and rem x, overflow gives min and rem 0
  always_comb begin
    if (div_zero) begin
      quot_s = '1;
      rem_s  = a_sx;
      quot_u = '1;
      rem_u  = src_a;
    end else begin
      quot_s = div_ovf ? a_sx : data_t'($signed(a_sx) / $signed(b_sx));
      rem_s  = div_ovf ? '0 : data_t'($signed(a_sx) % $signed(b_sx));
      quot_u = src_a / src_b;
      rem_u  = src_a % src_b;
    end
  end

  // halt, illegal and unknown ops fall to zero
  key_mux #(.key_w(5), .nr_key(16), .payload_t(data_t)) u_op_mux (
    .i_key    (i_ctrl.alu_op),
    .i_keys   ({exu_pkg::alu_copy, exu_pkg::alu_add, exu_pkg::alu_slt,
                exu_pkg::alu_sltu, exu_pkg::alu_sub, exu_pkg::alu_xor,
                exu_pkg::alu_and, exu_pkg::alu_or, exu_pkg::alu_sll,
                exu_pkg::alu_srl, exu_pkg::alu_sra, exu_pkg::alu_mul,
                exu_pkg::alu_div, exu_pkg::alu_divu, exu_pkg::alu_rem,
                exu_pkg::alu_remu}),
    .i_values ({i_ops.imm, sum, data_t'(less_s),
                data_t'(less_u), diff, src_a ^ src_b,
                src_a & src_b, src_a | src_b, sll_res,
                srl_res, sra_res, mul_res,
                quot_s, quot_u, rem_s,
                rem_u}),
    .i_default(data_t'(0)),
    .o_value  (raw_result)
  );

  assign o_result = i_ctrl.word_cut
                  ? {{(xlen-wlen){raw_result[wlen-1]}}, raw_result[wlen-1:0]}
                  : raw_result;

endmodule

// File: key_mux.sv
// keyed multiplexer: returns the payload whose key matches, else a default
`timescale 1ns/1ps

module key_mux #(
  parameter int  key_w  = 2,
  parameter int  nr_key = 2,
  parameter type payload_t = logic
) (
  input  logic     [key_w-1:0]              i_key,
  input  logic     [nr_key-1:0][key_w-1:0]  i_keys,
  input  payload_t [nr_key-1:0]             i_values,
  input  payload_t                          i_default,
  output payload_t                          o_value
);

  // linear search over the table, keys are expected to be unique
  always_comb begin
    o_value = i_default;
    for (int i = 0; i < nr_key; i++) begin
      if (i_keys[i] == i_key) begin
        o_value = i_values[i];
      end
    end
  end

endmodule

// File: exu_pkg.sv
// exu package: opcode encodings and the structs passed between execute blocks

`include "exu_settings.svh"

package exu_pkg;

  // alu operation codes
  typedef enum logic [4:0] {
    alu_add     = 5'b00000,
    alu_sll     = 5'b00001,
    alu_slt     = 5'b00010,
    alu_copy    = 5'b00011,
    alu_xor     = 5'b00100,
    alu_srl     = 5'b00101,
    alu_or      = 5'b00110,
    alu_and     = 5'b00111,
    alu_sub     = 5'b01000,
    alu_sltu    = 5'b01010,
    alu_sra     = 5'b01101,
    alu_remu    = 5'b11001,
    alu_divu    = 5'b11010,
    alu_div     = 5'b11011,
    alu_mul     = 5'b11100,
    alu_rem     = 5'b11101,
    alu_halt    = 5'b11110,
    alu_illegal = 5'b11111
  } alu_op_e;

  // branch kinds, compare flavour comes from the alu op
  typedef enum logic [2:0] {
    br_none = 3'b000,
    br_jal  = 3'b001,
    br_jalr = 3'b010,
    br_beq  = 3'b100,
    br_bne  = 3'b101,
    br_blt  = 3'b110,
    br_bge  = 3'b111
  } branch_e;

  typedef enum logic [2:0] {
    mem_lb  = 3'b000,
    mem_lbu = 3'b001,
    mem_lh  = 3'b010,
    mem_lhu = 3'b011,
    mem_lw  = 3'b100,
    mem_lwu = 3'b101,
    mem_ld  = 3'b110
  } mem_op_e;

  typedef enum logic [1:0] {
    b_rs2  = 2'b00,
    b_imm  = 2'b01,
    b_four = 2'b10
  } b_src_e;

  typedef struct packed {
    logic    a_from_pc;
    b_src_e  b_src;
    alu_op_e alu_op;
    logic    word_cut;
    branch_e branch;
    mem_op_e mem_op;
    logic    mem_to_reg;
  } exu_ctrl_t;

  typedef struct packed {
    logic [`EXU_XLEN-1:0] rs1;
    logic [`EXU_XLEN-1:0] rs2;
    logic [`EXU_XLEN-1:0] imm;
    logic [`EXU_XLEN-1:0] pc;
    logic [`EXU_XLEN-1:0] rdata;
  } exu_operands_t;

  typedef struct packed {
    logic zero;
    logic less;
  } alu_flags_t;

  typedef struct packed {
    logic [`EXU_XLEN-1:0] alu_result;
    logic [`EXU_XLEN-1:0] next_pc;
    logic [`EXU_XLEN-1:0] bus_w;
    logic                 halt;
    logic                 illegal;
  } exu_result_t;

endpackage

// File: exu_settings.svh
// exu settings: data path width and word operation width shared by the execute stage

`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// full register width of the RV64 data path
`define EXU_XLEN 64

// width of the *w word operations
`define EXU_WLEN 32

`endif
